//--- rtl/la32_defines.svh
`ifndef LA32_DEFINES_SVH
`define LA32_DEFINES_SVH

`define LA32_RESET_PC   32'h1c00_0000
`define LA32_RA_REG     5'd1

`define LA32_OP6_ALU    6'h00
`define LA32_OP6_LU12I  6'h05
`define LA32_OP6_MEM    6'h0a
`define LA32_OP6_JIRL   6'h13
`define LA32_OP6_B      6'h14
`define LA32_OP6_BL     6'h15
`define LA32_OP6_BEQ    6'h16
`define LA32_OP6_BNE    6'h17

`define LA32_OP4_3R     4'h0
`define LA32_OP4_SHIFT  4'h1
`define LA32_OP4_ADDI   4'ha
`define LA32_OP4_LD_W   4'h2
`define LA32_OP4_ST_W   4'h6

`define LA32_OP2_3R     2'h1
`define LA32_OP2_SHIFT  2'h0

`define LA32_OP5_ADD    5'h00
`define LA32_OP5_SUB    5'h02
`define LA32_OP5_SLT    5'h04
`define LA32_OP5_SLTU   5'h05
`define LA32_OP5_NOR    5'h08
`define LA32_OP5_AND    5'h09
`define LA32_OP5_OR     5'h0a
`define LA32_OP5_XOR    5'h0b
`define LA32_OP5_SLLI   5'h01
`define LA32_OP5_SRLI   5'h09
`define LA32_OP5_SRAI   5'h11

`endif

//--- rtl/la32_pkg.sv
package la32_pkg;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } cpu_state_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        NOR,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        br_kind_e    br_kind;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src_reg_is_rd;
        logic        rf_we;
        logic        mem_rd;
        logic        mem_wr;
        logic [4:0]  dest;
        logic [4:0]  rj;
        logic [4:0]  rk_or_rd;
        logic [31:0] imm;        // second operand when src2_is_imm is set.
        logic [31:0] br_offs;
    } dec_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } retire_t;

endpackage

//--- rtl/la32_decoder.sv
`include "la32_defines.svh"

module la32_decoder (
    input  logic [31:0]          insn,
    output la32_pkg::dec_ctrl_t  ctrl
);
    import la32_pkg::*;

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [4:0]  rd;
    logic [4:0]  rk;
    logic [31:0] ui5;
    logic [31:0] si12;
    logic [31:0] si16;
    logic [31:0] si20;
    logic [31:0] si26;

    assign op6  = insn[31:26];
    assign op4  = insn[25:22];
    assign op2  = insn[21:20];
    assign op5  = insn[19:15];
    assign rd   = insn[4:0];
    assign rk   = insn[14:10];

    assign ui5  = {27'b0, insn[14:10]};
    assign si12 = {{20{insn[21]}}, insn[21:10]};
    assign si16 = {{14{insn[25]}}, insn[25:10], 2'b0};  // word offset for jirl and branches.
    assign si20 = {insn[24:5], 12'b0};
    assign si26 = {{4{insn[9]}}, insn[9:0], insn[25:10], 2'b0};

    always_comb begin
        ctrl               = '0;        // unknown encodings fall through as no-operations.
        ctrl.alu_op        = ADD;
        ctrl.br_kind       = BR_NONE;
        ctrl.dest          = rd;
        ctrl.rj            = insn[9:5];
        ctrl.br_offs       = si16;
        case (op6)
            `LA32_OP6_ALU: begin
                if (op4 == `LA32_OP4_3R && op2 == `LA32_OP2_3R) begin
                    ctrl.rf_we = 1'b1;
                    case (op5)
                        `LA32_OP5_ADD:  ctrl.alu_op = ADD;
                        `LA32_OP5_SUB:  ctrl.alu_op = SUB;
                        `LA32_OP5_SLT:  ctrl.alu_op = SLT;
                        `LA32_OP5_SLTU: ctrl.alu_op = SLTU;
                        `LA32_OP5_NOR:  ctrl.alu_op = NOR;
                        `LA32_OP5_AND:  ctrl.alu_op = AND;
                        `LA32_OP5_OR:   ctrl.alu_op = OR;
                        `LA32_OP5_XOR:  ctrl.alu_op = XOR;
                        default:        ctrl.rf_we  = 1'b0;
                    endcase
                end else if (op4 == `LA32_OP4_SHIFT && op2 == `LA32_OP2_SHIFT) begin
                    ctrl.rf_we       = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = ui5;
                    case (op5)
                        `LA32_OP5_SLLI: ctrl.alu_op = SLL;
                        `LA32_OP5_SRLI: ctrl.alu_op = SRL;
                        `LA32_OP5_SRAI: ctrl.alu_op = SRA;
                        default:        ctrl.rf_we  = 1'b0;
                    endcase
                end else if (op4 == `LA32_OP4_ADDI) begin
                    ctrl.rf_we       = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = si12;
                end
            end
            `LA32_OP6_LU12I: begin
                ctrl.rf_we       = ~insn[25];   // the other half of this opcode is not supported.
                ctrl.alu_op      = LUI;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = si20;
            end
            `LA32_OP6_MEM: begin
                ctrl.src2_is_imm   = 1'b1;
                ctrl.imm           = si12;
                ctrl.mem_rd        = (op4 == `LA32_OP4_LD_W);
                ctrl.mem_wr        = (op4 == `LA32_OP4_ST_W);
                ctrl.rf_we         = (op4 == `LA32_OP4_LD_W);
                ctrl.src_reg_is_rd = (op4 == `LA32_OP4_ST_W);
            end
            `LA32_OP6_JIRL: begin
                ctrl.br_kind     = BR_JIRL;
                ctrl.rf_we       = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;       // link value is pc plus four.
            end
            `LA32_OP6_B, `LA32_OP6_BL: begin
                ctrl.br_kind     = (op6 == `LA32_OP6_BL) ? BR_BL : BR_B;
                ctrl.rf_we       = (op6 == `LA32_OP6_BL);
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
                ctrl.br_offs     = si26;
                if (op6 == `LA32_OP6_BL) begin
                    ctrl.dest = `LA32_RA_REG;
                end
            end
            `LA32_OP6_BEQ, `LA32_OP6_BNE: begin
                ctrl.br_kind       = (op6 == `LA32_OP6_BEQ) ? BR_BEQ : BR_BNE;
                ctrl.src_reg_is_rd = 1'b1;
            end
            default: ;
        endcase
        ctrl.rk_or_rd = ctrl.src_reg_is_rd ? rd : rk;
    end

endmodule

//--- rtl/la32_regfile.sv
module la32_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // register zero is hardwired, so its storage is never consulted.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- rtl/la32_execute.sv
module la32_execute (
    input  la32_pkg::dec_ctrl_t  ctrl,
    input  logic [31:0]          pc,
    input  logic [31:0]          rj_value,
    input  logic [31:0]          rkd_value,
    input  logic [31:0]          mem_rdata,
    output logic [31:0]          alu_result,
    output logic                 br_taken,
    output logic [31:0]          br_target,
    output logic [31:0]          wb_value
);
    import la32_pkg::*;

    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] sum;
    logic [4:0]  shamt;
    logic        rj_eq_rd;

    assign src1  = ctrl.src1_is_pc ? pc : rj_value;
    assign src2  = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign sum   = src1 + src2;
    assign shamt = src2[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = sum;
            SUB:     alu_result = src1 - src2;
            SLT:     alu_result = {31'b0, $signed(src1) < $signed(src2)};
            SLTU:    alu_result = {31'b0, src1 < src2};
            AND:     alu_result = src1 & src2;
            NOR:     alu_result = ~(src1 | src2);
            OR:      alu_result = src1 | src2;
            XOR:     alu_result = src1 ^ src2;
            SLL:     alu_result = src1 << shamt;
            SRL:     alu_result = src1 >> shamt;
            SRA:     alu_result = $unsigned($signed(src1) >>> shamt);
            LUI:     alu_result = src2;
            default: alu_result = sum;
        endcase
    end

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:                 br_taken = rj_eq_rd;
            BR_BNE:                 br_taken = ~rj_eq_rd;
            BR_B, BR_BL, BR_JIRL:   br_taken = 1'b1;
            default:                br_taken = 1'b0;
        endcase
    end

    // jirl jumps relative to its base register, all others relative to pc.
    assign br_target = ((ctrl.br_kind == BR_JIRL) ? rj_value : pc) + ctrl.br_offs;

    assign wb_value = ctrl.mem_rd ? mem_rdata : alu_result;

endmodule

//--- rtl/la32_sequencer.sv
`include "la32_defines.svh"

module la32_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    output la32_pkg::wb_req_t    ibus_req,
    input  la32_pkg::wb_rsp_t    ibus_rsp,
    output la32_pkg::wb_req_t    dbus_req,
    input  la32_pkg::wb_rsp_t    dbus_rsp,
    output logic [31:0]          insn,
    input  la32_pkg::dec_ctrl_t  ctrl,
    output logic [31:0]          pc,
    input  logic [31:0]          alu_result,
    input  logic                 br_taken,
    input  logic [31:0]          br_target,
    input  logic [31:0]          rkd_value,
    input  logic [31:0]          wb_value,
    output logic [31:0]          mem_rdata,
    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [31:0]          rf_wdata,
    output logic                 retire_valid,
    output la32_pkg::retire_t    retire
);
    import la32_pkg::*;

    cpu_state_e  state;
    logic        ibus_cyc;
    logic        dbus_cyc;
    logic [31:0] insn_q;
    logic [31:0] result_q;
    logic [31:0] store_q;
    logic [31:0] next_pc;
    logic        short_branch;
    logic        store_done;

    assign next_pc      = br_taken ? br_target : pc + 32'd4;
    assign short_branch = (ctrl.br_kind == BR_B) || (ctrl.br_kind == BR_BEQ) ||
                          (ctrl.br_kind == BR_BNE);  // these finish in decode.
    assign store_done   = (state == S_MEMORY) && dbus_cyc && dbus_rsp.ack && ctrl.mem_wr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_FETCH;
            pc       <= `LA32_RESET_PC;
            ibus_cyc <= 1'b0;
            dbus_cyc <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (!ibus_cyc) begin
                        ibus_cyc <= 1'b1;
                    end else if (ibus_rsp.ack) begin
                        ibus_cyc <= 1'b0;
                        state    <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (short_branch) begin
                        pc    <= next_pc;
                        state <= S_FETCH;
                    end else begin
                        state <= S_EXECUTE;
                    end
                end
                S_EXECUTE: begin
                    if (ctrl.mem_rd || ctrl.mem_wr) begin
                        dbus_cyc <= 1'b1;
                        state    <= S_MEMORY;
                    end else begin
                        state <= S_WRITEBACK;
                    end
                end
                S_MEMORY: begin
                    if (dbus_rsp.ack) begin
                        dbus_cyc <= 1'b0;
                        if (ctrl.mem_wr) begin
                            pc    <= next_pc;
                            state <= S_FETCH;
                        end else begin
                            state <= S_WRITEBACK;
                        end
                    end
                end
                S_WRITEBACK: begin
                    pc    <= next_pc;
                    state <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // the address is replaced by the loaded word once the access completes.
    always_ff @(posedge clk) begin
        if (state == S_FETCH && ibus_cyc && ibus_rsp.ack) begin
            insn_q <= ibus_rsp.dat;
        end
        if (state == S_EXECUTE) begin
            result_q <= alu_result;
            store_q  <= rkd_value;
        end else if (state == S_MEMORY && dbus_rsp.ack) begin
            result_q <= dbus_rsp.dat;
        end
    end

    assign ibus_req = '{cyc: ibus_cyc, stb: ibus_cyc, we: 1'b0, adr: pc,
                        dat: 32'd0, sel: 4'hf};
    assign dbus_req = '{cyc: dbus_cyc, stb: dbus_cyc, we: ctrl.mem_wr, adr: result_q,
                        dat: store_q, sel: 4'hf};

    assign insn      = insn_q;
    assign mem_rdata = result_q;

    assign rf_we    = (state == S_WRITEBACK) && ctrl.rf_we;
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = wb_value;

    assign retire_valid = ((state == S_DECODE) && short_branch) || store_done ||
                          (state == S_WRITEBACK);
    assign retire       = '{pc: pc, rf_we: rf_we, wnum: rf_we ? rf_waddr : 5'd0,
                            wdata: rf_we ? rf_wdata : 32'd0};

endmodule

//--- rtl/la32_cpu_top.sv
module la32_cpu_top (
    input  logic               clk,
    input  logic               reset,
    output la32_pkg::wb_req_t  ibus_req,
    input  la32_pkg::wb_rsp_t  ibus_rsp,
    output la32_pkg::wb_req_t  dbus_req,
    input  la32_pkg::wb_rsp_t  dbus_rsp,
    output logic               retire_valid,
    output la32_pkg::retire_t  retire
);
    import la32_pkg::*;

    dec_ctrl_t   ctrl;
    logic [31:0] insn;
    logic [31:0] pc;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] mem_rdata;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] wb_value;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    la32_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .ibus_req     (ibus_req),
        .ibus_rsp     (ibus_rsp),
        .dbus_req     (dbus_req),
        .dbus_rsp     (dbus_rsp),
        .insn         (insn),
        .ctrl         (ctrl),
        .pc           (pc),
        .alu_result   (alu_result),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .rkd_value    (rkd_value),
        .wb_value     (wb_value),
        .mem_rdata    (mem_rdata),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    la32_decoder u_decoder (
        .insn (insn),
        .ctrl (ctrl)
    );

    la32_regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rj),
        .rdata1 (rj_value),
        .raddr2 (ctrl.rk_or_rd),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    la32_execute u_execute (
        .ctrl       (ctrl),
        .pc         (pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_value   (wb_value)
    );

endmodule

//--- test/la32_tb_asserts.sv
module la32_tb_asserts (
    input logic                  clk,
    input logic                  reset,
    input la32_pkg::wb_req_t     ibus_req,
    input la32_pkg::wb_rsp_t     ibus_rsp,
    input la32_pkg::wb_req_t     dbus_req,
    input la32_pkg::wb_rsp_t     dbus_rsp,
    input la32_pkg::cpu_state_e  state,
    input logic                  retire_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    import la32_pkg::*;

    // the master ends its cycle right after the acknowledged transfer.
    ibus_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        ibus_req.cyc && ibus_rsp.ack |=> !ibus_req.stb && !ibus_req.cyc)
        else $error("instruction bus request held after its ack");

    dbus_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        dbus_req.cyc && dbus_rsp.ack |=> !dbus_req.stb && !dbus_req.cyc)
        else $error("data bus request held after its ack");

    // a request that is still waiting for ack keeps its address.
    ibus_adr_stable: assert property (@(posedge clk) disable iff (reset)
        ibus_req.stb && !ibus_rsp.ack |=> $stable(ibus_req.adr))
        else $error("instruction bus address changed during a wait state");

    dbus_adr_stable: assert property (@(posedge clk) disable iff (reset)
        dbus_req.stb && !dbus_rsp.ack |=> $stable(dbus_req.adr))
        else $error("data bus address changed during a wait state");

    // stores finish in the memory state on their ack.
    retire_state_ok: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> (state == S_DECODE || state == S_WRITEBACK ||
                          (state == S_MEMORY && dbus_rsp.ack && dbus_req.we)))
        else $error("retire outside decode, writeback or store completion");

endmodule

bind la32_sequencer la32_tb_asserts u_tb_asserts (
    .clk          (clk),
    .reset        (reset),
    .ibus_req     (ibus_req),
    .ibus_rsp     (ibus_rsp),
    .dbus_req     (dbus_req),
    .dbus_rsp     (dbus_rsp),
    .state        (state),
    .retire_valid (retire_valid)
);

//--- test/la32_tb.sv
`include "la32_defines.svh"

module la32_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import la32_pkg::*;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    wb_req_t     ibus_req;
    wb_rsp_t     ibus_rsp = '0;
    wb_req_t     dbus_req;
    wb_rsp_t     dbus_rsp = '0;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] prog_mem [logic [31:0]];
    logic [31:0] data_mem [logic [31:0]];
    int unsigned ibus_wait = 0;
    int unsigned dbus_wait = 0;
    logic        ibus_busy = 1'b0;
    logic        dbus_busy = 1'b0;
    string       exp_name [$];
    retire_t     exp_rec [$];
    int          cycle_count = 0;
    int          cycle_limit;

    la32_cpu_top UUT (
        .clk          (clk),
        .reset        (reset),
        .ibus_req     (ibus_req),
        .ibus_rsp     (ibus_rsp),
        .dbus_req     (dbus_req),
        .dbus_rsp     (dbus_rsp),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] enc_reg3(logic [31:0] base, logic [4:0] rd,
                                             logic [4:0] rj, logic [4:0] rk);
        return base | {17'b0, rk, rj, rd};              // rk also carries ui5 for shifts.
    endfunction

    function automatic logic [31:0] enc_imm12(logic [31:0] base, logic [4:0] rd,
                                              logic [4:0] rj, logic [11:0] imm);
        return base | {10'b0, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_offs16(logic [31:0] base, logic [4:0] rd,
                                               logic [4:0] rj, logic [15:0] offs);
        return base | {6'b0, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_offs26(logic [31:0] base, logic [25:0] offs);
        return base | {6'b0, offs[15:0], offs[25:16]};
    endfunction

    // an unplaced word reads back as its own address and so decodes as an undefined opcode.
    function automatic logic [31:0] fetch_word(logic [31:0] adr);
        return prog_mem.exists(adr) ? prog_mem[adr] : adr;
    endfunction

    function automatic logic [31:0] read_data(logic [31:0] adr);
        return data_mem.exists(adr) ? data_mem[adr] : adr ^ 32'h5a5a_5a5a;
    endfunction

    task automatic place_insn(int idx, logic [31:0] word);
        prog_mem[`LA32_RESET_PC + idx * 4] = word;
    endtask

    task automatic add_expected(string name, int idx, logic we, logic [4:0] wnum,
                                logic [31:0] wdata);
        retire_t rec;
        rec.pc    = `LA32_RESET_PC + idx * 4;
        rec.rf_we = we;
        rec.wnum  = wnum;
        rec.wdata = wdata;
        exp_name.push_back(name);
        exp_rec.push_back(rec);
    endtask

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    int place_marks [5] = '{22, 26, 28, 33, 34};                         // wrong-path slots.

    task automatic load_program();
        place_insn(0,  enc_imm12(32'h0280_0000, 5'd1, 5'd0, 12'd5));      // addi.w
        place_insn(1,  enc_imm12(32'h0280_0000, 5'd2, 5'd0, 12'hffd));
        place_insn(2,  enc_reg3(32'h0010_0000, 5'd3, 5'd1, 5'd2));         // add.w
        place_insn(3,  enc_reg3(32'h0011_0000, 5'd4, 5'd1, 5'd2));         // sub.w
        place_insn(4,  enc_reg3(32'h0012_0000, 5'd5, 5'd2, 5'd1));         // slt
        place_insn(5,  enc_reg3(32'h0012_8000, 5'd6, 5'd2, 5'd1));         // sltu
        place_insn(6,  enc_reg3(32'h0014_0000, 5'd7, 5'd1, 5'd2));         // nor
        place_insn(7,  enc_reg3(32'h0014_8000, 5'd8, 5'd1, 5'd2));         // and
        place_insn(8,  enc_reg3(32'h0015_0000, 5'd9, 5'd1, 5'd2));         // or
        place_insn(9,  enc_reg3(32'h0015_8000, 5'd10, 5'd1, 5'd2));        // xor
        place_insn(10, enc_reg3(32'h0040_8000, 5'd11, 5'd1, 5'd4));        // slli.w
        place_insn(11, enc_reg3(32'h0044_8000, 5'd12, 5'd2, 5'd4));        // srli.w
        place_insn(12, enc_reg3(32'h0048_8000, 5'd13, 5'd2, 5'd1));        // srai.w
        place_insn(13, 32'h1400_0000 | {7'b0, 20'h12345, 5'd14});         // lu12i.w
        place_insn(14, enc_imm12(32'h0280_0000, 5'd0, 5'd1, 12'd7));
        place_insn(15, enc_reg3(32'h0010_0000, 5'd15, 5'd0, 5'd1));
        place_insn(16, 32'h1400_0000 | {7'b0, 20'h00001, 5'd16});
        place_insn(17, enc_imm12(32'h2980_0000, 5'd14, 5'd16, 12'd8));     // st.w
        place_insn(18, enc_imm12(32'h2880_0000, 5'd17, 5'd16, 12'd8));     // ld.w
        place_insn(19, enc_imm12(32'h2980_0000, 5'd9, 5'd16, 12'hffc));
        place_insn(20, enc_imm12(32'h2880_0000, 5'd18, 5'd16, 12'hffc));
        place_insn(21, enc_offs16(32'h5800_0000, 5'd15, 5'd1, 16'd2));     // beq
        place_insn(23, enc_offs16(32'h5c00_0000, 5'd15, 5'd1, 16'd2));     // bne
        place_insn(24, enc_offs16(32'h5800_0000, 5'd2, 5'd1, 16'd2));
        place_insn(25, enc_offs16(32'h5c00_0000, 5'd2, 5'd1, 16'd2));
        place_insn(27, enc_offs26(32'h5000_0000, 26'd2));                 // b
        place_insn(29, enc_offs26(32'h5400_0000, 26'd3));                 // bl
        place_insn(30, enc_imm12(32'h0280_0000, 5'd20, 5'd0, 12'h077));
        place_insn(31, enc_offs26(32'h5000_0000, 26'd4));
        place_insn(32, enc_offs16(32'h4c00_0000, 5'd21, 5'd1, 16'd0));     // jirl
        place_insn(35, enc_reg3(32'h0010_0000, 5'd22, 5'd21, 5'd1));
        place_insn(36, enc_imm12(32'h2880_0000, 5'd23, 5'd16, 12'd16));
        foreach (place_marks[k]) begin
            place_insn(place_marks[k], enc_imm12(32'h0280_0000, 5'd19, 5'd0, 12'd1));
        end
    endtask

    task automatic load_expected();
        add_expected("addi.w r1", 0, 1'b1, 5'd1, 32'h0000_0005);
        add_expected("addi.w r2", 1, 1'b1, 5'd2, 32'hffff_fffd);
        add_expected("add.w", 2, 1'b1, 5'd3, 32'h0000_0002);
        add_expected("sub.w", 3, 1'b1, 5'd4, 32'h0000_0008);
        add_expected("slt", 4, 1'b1, 5'd5, 32'h0000_0001);
        add_expected("sltu", 5, 1'b1, 5'd6, 32'h0000_0000);
        add_expected("nor", 6, 1'b1, 5'd7, 32'h0000_0002);
        add_expected("and", 7, 1'b1, 5'd8, 32'h0000_0005);
        add_expected("or", 8, 1'b1, 5'd9, 32'hffff_fffd);
        add_expected("xor", 9, 1'b1, 5'd10, 32'hffff_fff8);
        add_expected("slli.w", 10, 1'b1, 5'd11, 32'h0000_0050);
        add_expected("srli.w", 11, 1'b1, 5'd12, 32'h0fff_ffff);
        add_expected("srai.w", 12, 1'b1, 5'd13, 32'hffff_fffe);
        add_expected("lu12i.w", 13, 1'b1, 5'd14, 32'h1234_5000);
        add_expected("addi.w r0", 14, 1'b1, 5'd0, 32'h0000_000c);
        add_expected("r0 reads zero", 15, 1'b1, 5'd15, 32'h0000_0005);
        add_expected("lu12i.w base", 16, 1'b1, 5'd16, 32'h0000_1000);
        add_expected("st.w +8", 17, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("ld.w +8", 18, 1'b1, 5'd17, 32'h1234_5000);
        add_expected("st.w -4", 19, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("ld.w -4", 20, 1'b1, 5'd18, 32'hffff_fffd);
        add_expected("beq taken", 21, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("bne not taken", 23, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("beq not taken", 24, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("bne taken", 25, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("b", 27, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("bl", 29, 1'b1, 5'd1, 32'h1c00_0078);
        add_expected("jirl", 32, 1'b1, 5'd21, 32'h1c00_0084);
        add_expected("return target", 30, 1'b1, 5'd20, 32'h0000_0077);
        add_expected("b to tail", 31, 1'b0, 5'd0, 32'h0000_0000);
        add_expected("add.w links", 35, 1'b1, 5'd22, 32'h3800_00fc);
        add_expected("ld.w unwritten", 36, 1'b1, 5'd23, 32'h5a5a_4a4a);
    endtask

    always @(posedge clk) begin
        int unsigned delay;
        if (reset) begin
            ibus_rsp  <= '0;
            ibus_busy <= 1'b0;
        end else if (ibus_rsp.ack) begin
            ibus_rsp.ack <= 1'b0;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            delay = ibus_busy ? ibus_wait : $urandom_range(3, 0);
            if (delay == 0) begin
                ibus_rsp.ack <= 1'b1;
                ibus_rsp.dat <= fetch_word(ibus_req.adr);
                ibus_busy    <= 1'b0;
            end else begin
                ibus_busy <= 1'b1;
                ibus_wait <= delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        int unsigned delay;
        if (reset) begin
            dbus_rsp  <= '0;
            dbus_busy <= 1'b0;
        end else if (dbus_rsp.ack) begin
            dbus_rsp.ack <= 1'b0;
        end else if (dbus_req.cyc && dbus_req.stb) begin
            delay = dbus_busy ? dbus_wait : $urandom_range(3, 0);
            if (delay == 0) begin
                if (dbus_req.we && dbus_req.sel == 4'hf) begin
                    data_mem[dbus_req.adr] = dbus_req.dat;
                end
                dbus_rsp.ack <= 1'b1;
                dbus_rsp.dat <= read_data(dbus_req.adr);
                dbus_busy    <= 1'b0;
            end else begin
                dbus_busy <= 1'b1;
                dbus_wait <= delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                stop_with_failure($sformatf("timeout after %0d cycles, trace incomplete",
                                            cycle_limit));
            end
        end
    end

    always @(negedge clk) begin
        if (reset && retire_valid === 1'b1) begin
            stop_with_failure("a retire was reported while reset was asserted");
        end
    end

    initial begin
        retire_t got;
        void'($urandom(32'hb0fb_efeb));
        load_program();
        load_expected();
        cycle_limit = exp_rec.size() * 40;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        foreach (exp_rec[i]) begin
            do begin
                @(negedge clk);
            end while (retire_valid !== 1'b1);
            got = retire;
            check_value({exp_name[i], " pc"}, exp_rec[i].pc, got.pc);
            check_value({exp_name[i], " rf_we"}, 32'(exp_rec[i].rf_we), 32'(got.rf_we));
            check_value({exp_name[i], " wnum"}, 32'(exp_rec[i].wnum), 32'(got.wnum));
            check_value({exp_name[i], " wdata"}, exp_rec[i].wdata, got.wdata);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/la32_pkg.sv
rtl/la32_decoder.sv
rtl/la32_regfile.sv
rtl/la32_execute.sv
rtl/la32_sequencer.sv
rtl/la32_cpu_top.sv
test/la32_tb_asserts.sv
test/la32_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the la32 testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        -f project.f --top-module la32_tb -Mdir obj_dir; then
    echo "ERROR: verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vla32_tb > sim.log 2>&1; then
    echo "ERROR: simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL, see sim.log"
    exit 1
fi
